// File: logic/uart_regs_pkg.sv
`default_nettype none

package uart_regs_pkg;

    // ******************************
    // Widths
    // ******************************
    localparam int UART_DATA_W     = 32;
    localparam int UART_ADR_W      = 5;
    localparam int UART_SEL_W      = 4;
    localparam int UART_FIFO_AW    = 2;
    // One extra bit for the wrap flag
    localparam int UART_FIFO_CNT_W = UART_FIFO_AW + 1;
    localparam int UART_INT_W      = 3;

    // Register offsets, word aligned
    localparam logic [UART_ADR_W-1:0] REG_INTF   = 5'h00;
    localparam logic [UART_ADR_W-1:0] REG_INTC   = 5'h04;
    localparam logic [UART_ADR_W-1:0] REG_MODE   = 5'h08;
    localparam logic [UART_ADR_W-1:0] REG_STATUS = 5'h0C;
    localparam logic [UART_ADR_W-1:0] REG_RXBUF  = 5'h10;
    localparam logic [UART_ADR_W-1:0] REG_TXBUF  = 5'h14;

    // Interrupt bits, shared by INTF, INTC and int_o
    localparam int INT_TX = 0;
    localparam int INT_RX = 1;
    localparam int INT_ER = 2;

    // MODE fields
    localparam int MODE_BRG_LSB    = 16;
    localparam int MODE_TXISEL_LSB = 12;
    localparam int MODE_RXISEL_LSB = 8;
    localparam int MODE_ENABLE_BIT = 7;

    // STATUS fields
    localparam int STS_TBC_LSB = 24;
    localparam int STS_RBC_LSB = 16;
    localparam int STS_TBE     = 15;
    localparam int STS_RBE     = 14;
    localparam int STS_TBF     = 13;
    localparam int STS_RBF     = 12;
    localparam int STS_TRMT    = 6;
    localparam int STS_TXBF    = 5;
    localparam int STS_RIDLE   = 4;
    localparam int STS_PERR    = 3;
    localparam int STS_FERR    = 2;
    localparam int STS_OERR    = 1;
    localparam int STS_RXDA    = 0;

    // ******************************
    // Payload and field types
    // ******************************
    typedef logic [7:0] uart_byte_t;

    // Received character with its line errors
    typedef struct packed {
        logic       ferr;
        logic       perr;
        uart_byte_t data;
    } uart_rx_entry_t;

    typedef logic [15:0]                uart_brg_t;
    typedef logic [1:0]                 uart_isel_t;
    typedef logic [UART_DATA_W-1:0]     uart_word_t;
    typedef logic [UART_FIFO_CNT_W-1:0] uart_cnt_t;

endpackage

`default_nettype wire

// File: logic/uart_fifo.sv
`default_nettype none

module uart_fifo import uart_regs_pkg::*; #(
    parameter type payload_t = uart_byte_t
) (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       push_i,
    input  payload_t  push_data_i,
    input  wire       pop_i,
    output payload_t  head_o,
    output uart_cnt_t count_o,
    output logic      empty_o,
    output logic      full_o
);

    // Storage, no reset on payload
    payload_t  mem [1 << UART_FIFO_AW];

    // Pointers carry a wrap bit above the index
    uart_cnt_t wr_ptr;
    uart_cnt_t rd_ptr;

    logic [UART_FIFO_AW-1:0] wr_idx;
    logic [UART_FIFO_AW-1:0] rd_idx;

    assign wr_idx = wr_ptr[UART_FIFO_AW-1:0];
    assign rd_idx = rd_ptr[UART_FIFO_AW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_idx] <= push_data_i;
        end
    end

    // Same index, wrap bits tell full from empty
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[UART_FIFO_AW] != rd_ptr[UART_FIFO_AW]) && (wr_idx == rd_idx);
    assign count_o = wr_ptr - rd_ptr;
    // Head shown without a read cycle
    assign head_o  = mem[rd_idx];

endmodule

`default_nettype wire

// File: logic/uart_wb_slave.sv
`default_nettype none

module uart_wb_slave import uart_regs_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    // Wishbone classic slave
    input  wire                   cyc_i,
    input  wire                   stb_i,
    input  wire                   we_i,
    input  wire  [UART_ADR_W-1:0] adr_i,
    input  uart_word_t            dat_i,
    input  wire  [UART_SEL_W-1:0] sel_i,
    output logic                  ack_o,
    output uart_word_t            dat_o,
    // Read sources
    input  uart_word_t            intf_i,
    input  uart_word_t            intc_i,
    input  uart_word_t            mode_i,
    input  uart_word_t            status_i,
    input  uart_word_t            rxbuf_i,
    // FIFO guards
    input  wire                   tx_full_i,
    input  wire                   rx_empty_i,
    // Register strobes
    output uart_word_t            wr_dat_o,
    output logic [UART_SEL_W-1:0] wr_sel_o,
    output logic                  intf_we_o,
    output logic                  intc_we_o,
    output logic                  mode_we_o,
    output logic                  txbuf_we_o,
    output logic                  rxbuf_re_o
);

    logic       accept;
    logic       wr_acc;
    logic       rd_acc;
    uart_word_t rd_word;

    // New cycle only while no ack is out, so one ack per access
    assign accept = cyc_i & stb_i & ~ack_o;
    assign wr_acc = accept & we_i;
    assign rd_acc = accept & ~we_i;

    // Strobes land on the edge that raises ack
    assign intf_we_o  = wr_acc & (adr_i == REG_INTF);
    assign intc_we_o  = wr_acc & (adr_i == REG_INTC);
    assign mode_we_o  = wr_acc & (adr_i == REG_MODE);
    // Full FIFO drops the write
    assign txbuf_we_o = wr_acc & (adr_i == REG_TXBUF) & ~tx_full_i;
    // Empty FIFO keeps the stale head, no pop
    assign rxbuf_re_o = rd_acc & (adr_i == REG_RXBUF) & ~rx_empty_i;

    assign wr_dat_o = dat_i;
    assign wr_sel_o = sel_i;

    // Read mux, TXBUF and holes read zero
    always_comb begin
        case (adr_i)
            REG_INTF:   rd_word = intf_i;
            REG_INTC:   rd_word = intc_i;
            REG_MODE:   rd_word = mode_i;
            REG_STATUS: rd_word = status_i;
            REG_RXBUF:  rd_word = rxbuf_i;
            default:    rd_word = '0;
        endcase
    end

    // Single cycle acknowledge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= accept;
        end
    end

    // Read data valid together with ack
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            dat_o <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: logic/uart_irq_ctrl.sv
`default_nettype none

module uart_irq_ctrl import uart_regs_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    // Register writes
    input  wire                   intf_we_i,
    input  wire                   intc_we_i,
    input  uart_word_t            wr_dat_i,
    input  wire  [UART_SEL_W-1:0] wr_sel_i,
    // Trigger selects from MODE
    input  uart_isel_t            txisel_i,
    input  uart_isel_t            rxisel_i,
    // Events
    input  wire                   tsr_empty_i,
    input  wire                   tsr_push_i,
    input  wire                   tx_empty_i,
    input  wire                   rsr_pull_i,
    input  uart_cnt_t             rx_count_i,
    input  wire                   ferr_i,
    input  wire                   perr_i,
    // Outputs
    output uart_word_t            intf_o,
    output uart_word_t            intc_o,
    output logic [UART_INT_W-1:0] int_o
);

    logic [UART_INT_W-1:0] flags;
    logic [UART_INT_W-1:0] enables;
    logic [UART_INT_W-1:0] flag_set;
    logic [UART_INT_W-1:0] flag_clr;
    logic                  tsr_empty_d;
    logic                  tx_empty_d;

    // Edge detect history, idle means both high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tsr_empty_d <= 1'b1;
            tx_empty_d  <= 1'b1;
        end else begin
            tsr_empty_d <= tsr_empty_i;
            tx_empty_d  <= tx_empty_i;
        end
    end

    // ******************************
    // Set conditions
    // ******************************
    always_comb begin
        flag_set         = '0;
        flag_set[INT_ER] = rsr_pull_i & (ferr_i | perr_i);
        // Count is sampled before the new byte goes in
        case (rxisel_i)
            2'd2:    flag_set[INT_RX] = rsr_pull_i & (rx_count_i == uart_cnt_t'(2));
            2'd3:    flag_set[INT_RX] = rsr_pull_i & (rx_count_i == uart_cnt_t'(3));
            default: flag_set[INT_RX] = rsr_pull_i;
        endcase
        case (txisel_i)
            2'd1:    flag_set[INT_TX] = tsr_empty_i & ~tsr_empty_d & tx_empty_i;
            2'd2:    flag_set[INT_TX] = tx_empty_i & ~tx_empty_d;
            default: flag_set[INT_TX] = tsr_push_i;
        endcase
    end

    // W1C, all flags live in byte 0
    assign flag_clr = (intf_we_i & wr_sel_i[0]) ? wr_dat_i[UART_INT_W-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags   <= '0;
            enables <= '0;
        end else begin
            // Set beats a clear in the same cycle
            flags <= (flags & ~flag_clr) | flag_set;
            if (intc_we_i && wr_sel_i[0]) begin
                enables <= wr_dat_i[UART_INT_W-1:0];
            end
        end
    end

    assign intf_o = {{(UART_DATA_W-UART_INT_W){1'b0}}, flags};
    assign intc_o = {{(UART_DATA_W-UART_INT_W){1'b0}}, enables};
    assign int_o  = flags & enables;

endmodule

`default_nettype wire

// File: logic/uart_line_ctrl.sv
`default_nettype none

module uart_line_ctrl import uart_regs_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    // MODE write
    input  wire                   mode_we_i,
    input  uart_word_t            wr_dat_i,
    input  wire  [UART_SEL_W-1:0] wr_sel_i,
    // MODE fields
    output uart_word_t            mode_o,
    output uart_isel_t            txisel_o,
    output uart_isel_t            rxisel_o,
    output logic                  enable_o,
    output logic                  brg_sample_o,
    // Shift register side and FIFO flags
    input  wire                   tsr_empty_i,
    input  wire                   tx_empty_i,
    input  wire                   rsr_full_i,
    input  wire                   rx_full_i,
    input  wire                   rx_empty_i,
    output logic                  tsr_push_o,
    output logic                  rsr_pull_o,
    output logic                  oerr_o
);

    uart_brg_t  brg;
    uart_brg_t  brg_cnt;
    uart_isel_t txisel;
    uart_isel_t rxisel;
    logic       enable;

    // ******************************
    // MODE register
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            brg    <= '0;
            txisel <= '0;
            rxisel <= '0;
            enable <= 1'b0;
        end else if (mode_we_i) begin
            // BRG spans bytes 2 and 3
            if (wr_sel_i[2]) begin
                brg[7:0] <= wr_dat_i[23:16];
            end
            if (wr_sel_i[3]) begin
                brg[15:8] <= wr_dat_i[31:24];
            end
            // Both selects in byte 1
            if (wr_sel_i[1]) begin
                txisel <= wr_dat_i[MODE_TXISEL_LSB +: 2];
                rxisel <= wr_dat_i[MODE_RXISEL_LSB +: 2];
            end
            if (wr_sel_i[0]) begin
                enable <= wr_dat_i[MODE_ENABLE_BIT];
            end
        end
    end

    // Reserved bits stay zero
    always_comb begin
        mode_o                          = '0;
        mode_o[MODE_BRG_LSB +: 16]      = brg;
        mode_o[MODE_TXISEL_LSB +: 2]    = txisel;
        mode_o[MODE_RXISEL_LSB +: 2]    = rxisel;
        mode_o[MODE_ENABLE_BIT]         = enable;
    end

    assign txisel_o = txisel;
    assign rxisel_o = rxisel;
    assign enable_o = enable;

    // Baud counter, tick at zero then reload, N+1 period
    assign brg_sample_o = (brg_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            brg_cnt <= '0;
        end else if (brg_sample_o) begin
            brg_cnt <= brg;
        end else begin
            brg_cnt <= brg_cnt - 1'b1;
        end
    end

    // Level handshakes, byte moves on the edge
    assign tsr_push_o = tsr_empty_i & ~tx_empty_i;
    // Held low on a full FIFO as back-pressure
    assign rsr_pull_o = rsr_full_i & ~rx_full_i;

    // Overrun sticks until software drains the FIFO
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            oerr_o <= 1'b0;
        end else if (rsr_full_i && rx_full_i) begin
            oerr_o <= 1'b1;
        end else if (rx_empty_i) begin
            oerr_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/uart_regs.sv
`default_nettype none

module uart_regs import uart_regs_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    // Wishbone
    input  wire                   wb_cyc_i,
    input  wire                   wb_stb_i,
    input  wire                   wb_we_i,
    input  wire  [UART_ADR_W-1:0] wb_adr_i,
    input  uart_word_t            wb_dat_i,
    input  wire  [UART_SEL_W-1:0] wb_sel_i,
    output logic                  wb_ack_o,
    output uart_word_t            wb_dat_o,
    output logic [UART_INT_W-1:0] int_o,
    // Transmit shift register
    input  wire                   tsr_empty_i,
    output logic                  tsr_push_o,
    output uart_byte_t            tsr_byte_o,
    // Receive shift register
    input  wire                   rsr_empty_i,
    input  wire                   rsr_full_i,
    input  uart_byte_t            rsr_byte_i,
    input  wire                   ferr_i,
    input  wire                   perr_i,
    output logic                  rsr_pull_o,
    // Line control
    output logic                  enable_o,
    output logic                  brg_sample_o
);

    uart_word_t            intf_word, intc_word, mode_word, status_word, rxbuf_word;
    uart_word_t            wr_dat;
    logic [UART_SEL_W-1:0] wr_sel;
    logic                  intf_we, intc_we, mode_we, txbuf_we, rxbuf_re;
    logic                  tx_empty, tx_full, rx_empty, rx_full, oerr;
    uart_cnt_t             tx_count, rx_count;
    uart_isel_t            txisel, rxisel;
    uart_rx_entry_t        rx_in, rx_head;

    uart_wb_slave u_wb_slave (
        .clk(clk), .rst_n(rst_n),
        .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .we_i(wb_we_i), .adr_i(wb_adr_i),
        .dat_i(wb_dat_i), .sel_i(wb_sel_i), .ack_o(wb_ack_o), .dat_o(wb_dat_o),
        .intf_i(intf_word), .intc_i(intc_word), .mode_i(mode_word),
        .status_i(status_word), .rxbuf_i(rxbuf_word),
        .tx_full_i(tx_full), .rx_empty_i(rx_empty),
        .wr_dat_o(wr_dat), .wr_sel_o(wr_sel),
        .intf_we_o(intf_we), .intc_we_o(intc_we), .mode_we_o(mode_we),
        .txbuf_we_o(txbuf_we), .rxbuf_re_o(rxbuf_re)
    );

    // TX side, bus in and shift register out
    uart_fifo #(.payload_t(uart_byte_t)) tx_fifo (
        .clk(clk), .rst_n(rst_n),
        .push_i(txbuf_we), .push_data_i(wr_dat[7:0]), .pop_i(tsr_push_o),
        .head_o(tsr_byte_o), .count_o(tx_count), .empty_o(tx_empty), .full_o(tx_full)
    );

    // RX side keeps the error bits with each byte
    assign rx_in = '{ferr: ferr_i, perr: perr_i, data: rsr_byte_i};

    uart_fifo #(.payload_t(uart_rx_entry_t)) rx_fifo (
        .clk(clk), .rst_n(rst_n),
        .push_i(rsr_pull_o), .push_data_i(rx_in), .pop_i(rxbuf_re),
        .head_o(rx_head), .count_o(rx_count), .empty_o(rx_empty), .full_o(rx_full)
    );

    uart_irq_ctrl u_irq_ctrl (
        .clk(clk), .rst_n(rst_n),
        .intf_we_i(intf_we), .intc_we_i(intc_we), .wr_dat_i(wr_dat), .wr_sel_i(wr_sel),
        .txisel_i(txisel), .rxisel_i(rxisel),
        .tsr_empty_i(tsr_empty_i), .tsr_push_i(tsr_push_o), .tx_empty_i(tx_empty),
        .rsr_pull_i(rsr_pull_o), .rx_count_i(rx_count), .ferr_i(ferr_i), .perr_i(perr_i),
        .intf_o(intf_word), .intc_o(intc_word), .int_o(int_o)
    );

    uart_line_ctrl u_line_ctrl (
        .clk(clk), .rst_n(rst_n),
        .mode_we_i(mode_we), .wr_dat_i(wr_dat), .wr_sel_i(wr_sel),
        .mode_o(mode_word), .txisel_o(txisel), .rxisel_o(rxisel),
        .enable_o(enable_o), .brg_sample_o(brg_sample_o),
        .tsr_empty_i(tsr_empty_i), .tx_empty_i(tx_empty), .rsr_full_i(rsr_full_i),
        .rx_full_i(rx_full), .rx_empty_i(rx_empty),
        .tsr_push_o(tsr_push_o), .rsr_pull_o(rsr_pull_o), .oerr_o(oerr)
    );

    // ******************************
    // STATUS and RXBUF words
    // ******************************
    always_comb begin
        status_word                              = '0;
        status_word[STS_TBC_LSB +: $bits(uart_byte_t)] = uart_byte_t'(tx_count);
        status_word[STS_RBC_LSB +: $bits(uart_byte_t)] = uart_byte_t'(rx_count);
        status_word[STS_TBE]   = tx_empty;
        status_word[STS_RBE]   = rx_empty;
        status_word[STS_TBF]   = tx_full;
        status_word[STS_RBF]   = rx_full;
        // Whole transmit path idle
        status_word[STS_TRMT]  = tsr_empty_i & tx_empty;
        status_word[STS_TXBF]  = tx_full;
        status_word[STS_RIDLE] = rsr_empty_i;
        // Errors of the byte at the head
        status_word[STS_PERR]  = rx_head.perr;
        status_word[STS_FERR]  = rx_head.ferr;
        status_word[STS_OERR]  = oerr;
        status_word[STS_RXDA]  = ~rx_empty;
    end

    assign rxbuf_word = {{(UART_DATA_W-$bits(uart_byte_t)){1'b0}}, rx_head.data};

endmodule

`default_nettype wire

// File: tests/uart_regs_properties.sv
`default_nettype none

module uart_regs_properties import uart_regs_pkg::*; (
    input wire                       clk,
    input wire                       rst_n,
    input wire                       ack_i,
    input wire [UART_FIFO_CNT_W-1:0] tx_count_i,
    input wire [UART_FIFO_CNT_W-1:0] rx_count_i
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 1 << UART_FIFO_AW;

    // ******************************
    // Bus handshake
    // ******************************
    // Ack is a single cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack_i |=> !ack_i)
        else $error("wb_ack_o stayed high for more than one cycle");

    // ******************************
    // FIFO guards
    // ******************************
    // Push while full or pop while empty throws the count past the depth
    tx_guard: assert property (@(posedge clk) disable iff (!rst_n) tx_count_i <= DEPTH)
        else $error("TX FIFO count past its depth, pushed while full");

    rx_guard: assert property (@(posedge clk) disable iff (!rst_n) rx_count_i <= DEPTH)
        else $error("RX FIFO count past its depth, popped while empty");

endmodule

// Hooked onto the ack and the FIFO counts of the top level
bind uart_regs uart_regs_properties u_properties (
    .clk(clk),
    .rst_n(rst_n),
    .ack_i(wb_ack_o),
    .tx_count_i(tx_count),
    .rx_count_i(rx_count)
);

`default_nettype wire

// File: tests/uart_regs_tb.sv
`default_nettype none

module uart_regs_tb import uart_regs_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 32;
    // Longest run of the baud counter plus margin
    localparam int BRG_LIMIT  = (1 << $bits(uart_brg_t)) + 4;

    logic                  clk;
    logic                  rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [UART_ADR_W-1:0] wb_adr;
    uart_word_t            wb_dat;
    logic [UART_SEL_W-1:0] wb_sel;
    logic                  wb_ack;
    uart_word_t            wb_rdat;
    logic [UART_INT_W-1:0] irq;
    logic                  tsr_empty;
    logic                  tsr_push;
    uart_byte_t            tsr_byte;
    logic                  rsr_empty;
    logic                  rsr_full;
    uart_byte_t            rsr_byte;
    logic                  ferr;
    logic                  perr;
    logic                  rsr_pull;
    logic                  enable;
    logic                  brg_sample;

    int check_count;
    int error_count;
    int seed;

    uart_regs UUT (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat), .wb_sel_i(wb_sel), .wb_ack_o(wb_ack), .wb_dat_o(wb_rdat),
        .int_o(irq),
        .tsr_empty_i(tsr_empty), .tsr_push_o(tsr_push), .tsr_byte_o(tsr_byte),
        .rsr_empty_i(rsr_empty), .rsr_full_i(rsr_full), .rsr_byte_i(rsr_byte),
        .ferr_i(ferr), .perr_i(perr), .rsr_pull_o(rsr_pull),
        .enable_o(enable), .brg_sample_o(brg_sample)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // ******************************
    // Compare tasks
    // ******************************
    task automatic check_word(input string name, input uart_word_t got, input uart_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_result(input string name, input int errs_before);
        $display("%-12s %0d errors", name, error_count - errs_before);
    endtask

    // ******************************
    // Bus and line tasks
    // ******************************
    // One Wishbone classic access, held until ack
    task automatic bus_cycle(input logic we, input logic [UART_ADR_W-1:0] adr,
                             input uart_word_t dat, input logic [UART_SEL_W-1:0] sel,
                             output uart_word_t rdat);
        int n;
        n = 0;
        rdat = '0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat = dat;
        wb_sel = sel;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < WAIT_LIMIT);
        if (wb_ack) begin
            rdat = wb_rdat;
        end else begin
            error_count++;
            $display("No acknowledge from the bus slave at address 0x%h", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [UART_ADR_W-1:0] adr, input uart_word_t dat,
                            input logic [UART_SEL_W-1:0] sel);
        uart_word_t unused;
        bus_cycle(1'b1, adr, dat, sel, unused);
    endtask

    task automatic wb_read(input logic [UART_ADR_W-1:0] adr, output uart_word_t rdat);
        bus_cycle(1'b0, adr, '0, '1, rdat);
    endtask

    // Byte offered by the receive shift register, held until pulled
    task automatic offer_rx(input uart_byte_t data, input logic fe, input logic pe,
                            input int limit, output logic pulled);
        int n;
        n = 0;
        pulled = 1'b0;
        @(negedge clk);
        rsr_byte = data;
        ferr = fe;
        perr = pe;
        rsr_full = 1'b1;
        while (!pulled && n < limit) begin
            // Pull is combinational, look once inputs settle
            #1;
            pulled = rsr_pull;
            @(negedge clk);
            n++;
        end
        rsr_full = 1'b0;
        ferr = 1'b0;
        perr = 1'b0;
    endtask

    task automatic wait_irq(input int bit_idx, output logic seen);
        int n;
        n = 0;
        seen = irq[bit_idx];
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = irq[bit_idx];
            n++;
        end
    endtask

    // Cycles up to the next rising edge of brg_sample_o, -1 on timeout
    task automatic sample_gap(input int limit, output int gap);
        logic prev;
        int   n;
        prev = brg_sample;
        n = 0;
        gap = -1;
        while (gap < 0 && n < limit) begin
            @(negedge clk);
            n++;
            if (!prev && brg_sample) begin
                gap = n;
            end
            prev = brg_sample;
        end
    endtask

    // ******************************
    // Directed tests
    // ******************************
    task automatic reset_and_registers();
        uart_word_t rd;
        uart_word_t exp_status;
        int         errs;
        errs = error_count;
        wb_read(REG_INTF, rd);
        check_word("INTF", rd, '0);
        wb_read(REG_INTC, rd);
        check_word("INTC", rd, '0);
        wb_read(REG_MODE, rd);
        check_word("MODE", rd, '0);
        wb_read(REG_TXBUF, rd);
        check_word("TXBUF", rd, '0);
        exp_status = '0;
        exp_status[STS_TBE] = 1'b1;
        exp_status[STS_RBE] = 1'b1;
        exp_status[STS_RIDLE] = 1'b1;
        wb_read(REG_STATUS, rd);
        // Head error bits are undefined while RX is empty
        rd[STS_PERR] = 1'b0;
        rd[STS_FERR] = 1'b0;
        check_word("STATUS", rd, exp_status);
        // RIDLE tracks the receive shift register
        rsr_empty = 1'b0;
        wb_read(REG_STATUS, rd);
        check_bit("STATUS.RIDLE", rd[STS_RIDLE], 1'b0);
        rsr_empty = 1'b1;
        // Enables live in byte 0 only
        wb_write(REG_INTC, 32'hFFFF_FFFF, 4'b0001);
        wb_read(REG_INTC, rd);
        check_word("INTC", rd, 32'h0000_0007);
        wb_write(REG_INTC, 32'h0000_0000, 4'b1110);
        wb_read(REG_INTC, rd);
        check_word("INTC", rd, 32'h0000_0007);
        wb_write(REG_INTC, 32'h0000_0000, 4'b1111);
        // Low divisor byte alone
        wb_write(REG_MODE, 32'hFFFF_FFFF, 4'b0100);
        wb_read(REG_MODE, rd);
        check_word("MODE", rd, 32'h00FF_0000);
        // High divisor, both selects, ENABLE; reserved bits drop out
        wb_write(REG_MODE, 32'h1234_3381, 4'b1011);
        wb_read(REG_MODE, rd);
        check_word("MODE", rd, 32'h12FF_3380);
        check_bit("enable_o", enable, 1'b1);
        wb_write(REG_MODE, 32'h0000_0000, 4'b1111);
        check_bit("enable_o", enable, 1'b0);
        report_result("registers", errs);
    endtask

    task automatic transmit_path();
        uart_byte_t sent [5];
        uart_word_t rd;
        int         errs;
        errs = error_count;
        tsr_empty = 1'b0;
        for (int i = 0; i < 5; i++) begin
            sent[i] = uart_byte_t'($urandom);
            wb_write(REG_TXBUF, {24'h0, sent[i]}, 4'b0001);
        end
        // Fifth write dropped on a full FIFO
        wb_read(REG_STATUS, rd);
        check_byte("STATUS.TBC", rd[STS_TBC_LSB +: 8], 8'd4);
        check_bit("STATUS.TBF", rd[STS_TBF], 1'b1);
        check_bit("STATUS.TBE", rd[STS_TBE], 1'b0);
        @(negedge clk);
        check_byte("tsr_byte_o", tsr_byte, sent[0]);
        tsr_empty = 1'b1;
        // One byte leaves per cycle
        for (int i = 1; i < 4; i++) begin
            @(negedge clk);
            check_bit("tsr_push_o", tsr_push, 1'b1);
            check_byte("tsr_byte_o", tsr_byte, sent[i]);
        end
        @(negedge clk);
        check_bit("tsr_push_o", tsr_push, 1'b0);
        wb_read(REG_STATUS, rd);
        check_bit("STATUS.TRMT", rd[STS_TRMT], 1'b1);
        check_bit("STATUS.TBE", rd[STS_TBE], 1'b1);
        check_byte("STATUS.TBC", rd[STS_TBC_LSB +: 8], 8'd0);
        tsr_empty = 1'b0;
        // Shift register busy again, so not idle
        wb_read(REG_STATUS, rd);
        check_bit("STATUS.TRMT", rd[STS_TRMT], 1'b0);
        wb_write(REG_INTF, 32'h0000_0007, 4'b0001);
        report_result("transmit", errs);
    endtask

    task automatic receive_path();
        uart_byte_t data [4];
        logic [3:0] fe_bits;
        logic [3:0] pe_bits;
        logic       pulled;
        uart_word_t rd;
        int         errs;
        errs = error_count;
        fe_bits = 4'b1100;
        pe_bits = 4'b1010;
        for (int i = 0; i < 4; i++) begin
            data[i] = uart_byte_t'($urandom);
            offer_rx(data[i], fe_bits[i], pe_bits[i], WAIT_LIMIT, pulled);
            if (!pulled) begin
                error_count++;
                $display("Receive offer %0d was never pulled", i);
            end
        end
        // FIFO full, the fifth byte is held off
        offer_rx(uart_byte_t'($urandom), 1'b0, 1'b0, 4, pulled);
        check_bit("rsr_pull_o", pulled, 1'b0);
        wb_read(REG_STATUS, rd);
        check_bit("STATUS.OERR", rd[STS_OERR], 1'b1);
        check_bit("STATUS.RBF", rd[STS_RBF], 1'b1);
        for (int i = 0; i < 4; i++) begin
            wb_read(REG_STATUS, rd);
            check_byte("STATUS.RBC", rd[STS_RBC_LSB +: 8], uart_byte_t'(4 - i));
            check_bit("STATUS.PERR", rd[STS_PERR], pe_bits[i]);
            check_bit("STATUS.FERR", rd[STS_FERR], fe_bits[i]);
            wb_read(REG_RXBUF, rd);
            check_word("RXBUF", rd, {24'h0, data[i]});
        end
        // Overrun gone once drained
        wb_read(REG_STATUS, rd);
        check_bit("STATUS.OERR", rd[STS_OERR], 1'b0);
        check_bit("STATUS.RBE", rd[STS_RBE], 1'b1);
        wb_write(REG_INTF, 32'h0000_0007, 4'b0001);
        report_result("receive", errs);
    endtask

    task automatic interrupt_flags();
        logic       pulled;
        logic       seen;
        uart_word_t rd;
        int         errs;
        errs = error_count;
        // RX with RXISEL 0, every pull
        wb_write(REG_INTC, uart_word_t'(1 << INT_RX), 4'b0001);
        offer_rx(uart_byte_t'($urandom), 1'b0, 1'b0, WAIT_LIMIT, pulled);
        check_bit("int_o[RX]", irq[INT_RX], 1'b1);
        wb_write(REG_INTF, uart_word_t'(1 << INT_RX), 4'b0001);
        check_bit("int_o[RX]", irq[INT_RX], 1'b0);
        wb_read(REG_RXBUF, rd);
        // Framing error on the byte
        wb_write(REG_INTC, uart_word_t'(1 << INT_ER), 4'b0001);
        offer_rx(uart_byte_t'($urandom), 1'b1, 1'b0, WAIT_LIMIT, pulled);
        check_bit("int_o[ER]", irq[INT_ER], 1'b1);
        wb_read(REG_INTF, rd);
        check_word("INTF", rd, uart_word_t'((1 << INT_ER) | (1 << INT_RX)));
        wb_read(REG_RXBUF, rd);
        wb_write(REG_INTF, 32'h0000_0007, 4'b0001);
        // TXISEL 2, flag on the TX FIFO going empty
        wb_write(REG_MODE, uart_word_t'(2 << MODE_TXISEL_LSB), 4'b0010);
        wb_write(REG_INTC, uart_word_t'(1 << INT_TX), 4'b0001);
        wb_write(REG_TXBUF, uart_word_t'($urandom), 4'b0001);
        wb_write(REG_TXBUF, uart_word_t'($urandom), 4'b0001);
        check_bit("int_o[TX]", irq[INT_TX], 1'b0);
        tsr_empty = 1'b1;
        wait_irq(INT_TX, seen);
        check_count++;
        if (!seen) begin
            error_count++;
            $display("TX interrupt never rose after the TX FIFO drained");
        end
        tsr_empty = 1'b0;
        wb_write(REG_INTF, 32'h0000_0007, 4'b0001);
        wb_write(REG_INTC, 32'h0000_0000, 4'b0001);
        wb_write(REG_MODE, 32'h0000_0000, 4'b1111);
        report_result("interrupts", errs);
    endtask

    task automatic baud_counter();
        int divs [2];
        int gap;
        int errs;
        errs = error_count;
        divs[0] = 3;
        divs[1] = 6;
        for (int k = 0; k < 2; k++) begin
            wb_write(REG_MODE, uart_word_t'(divs[k]) << MODE_BRG_LSB, 4'b1100);
            // Counter runs out its old load first, the next edge reloads the new divisor
            sample_gap(BRG_LIMIT, gap);
            sample_gap(WAIT_LIMIT, gap);
            if (gap < 0) begin
                error_count++;
                $display("brg_sample_o stopped pulsing with divisor %0d", divs[k]);
            end else begin
                check_word("brg_sample_o period", uart_word_t'(gap), uart_word_t'(divs[k] + 1));
            end
        end
        wb_write(REG_MODE, 32'h0000_0000, 4'b1111);
        report_result("baud", errs);
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        seed = 70833;
        void'($urandom(seed));
        check_count = 0;
        error_count = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        wb_sel = '0;
        tsr_empty = 1'b0;
        rsr_empty = 1'b1;
        rsr_full = 1'b0;
        rsr_byte = '0;
        ferr = 1'b0;
        perr = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_and_registers();
        transmit_path();
        receive_path();
        interrupt_flags();
        baud_counter();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_regs.f
logic/uart_regs_pkg.sv
logic/uart_fifo.sv
logic/uart_wb_slave.sv
logic/uart_irq_ctrl.sv
logic/uart_line_ctrl.sv
logic/uart_regs.sv
tests/uart_regs_properties.sv
tests/uart_regs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the uart_regs testbench with Verilator, run it, then judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f uart_regs.f --top-module uart_regs_tb \
    && ./obj_dir/Vuart_regs_tb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
